// File: hdl/control_unit.sv
// main control decoder

`timescale 1ns/1ps

`include "rv_cfg.svh"

module control_unit
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
(
   input  opcode_e             opcode,
   input  logic [`RV_XLEN-1:0] predicted_pc,
   input  logic                branch_taken,
   decode_if.ctrl_src          dec
);

   ctrl_t ctrl;
   logic  flush;

   // control table as in Figure 4.18, one opcode per arm
   always_comb begin
      ctrl  = CTRL_NOP;
      flush = 1'b0;
      case (opcode)
         OP_ALU_R: begin
            ctrl.alu_op    = ALU_R_TYPE;
            ctrl.reg_write = 1'b1;
         end

         OP_ALU_I: begin
            ctrl.alu_op    = ALU_ADD;
            ctrl.alu_src   = 1'b1;
            ctrl.reg_write = 1'b1;
         end

         OP_BRANCH_EQ: begin
            // subtract to compare rs1 and rs2
            ctrl.alu_op = ALU_SUB;
            ctrl.branch = 1'b1;
            // taken branch kills the slot behind it
            flush       = branch_taken;
         end

         OP_JUMP: begin
            // ALU unused by jal, leave it on add
            ctrl.alu_op = ALU_ADD;
            ctrl.jump   = 1'b1;
            // zero prediction means fetch went on sequentially
            flush       = ~|predicted_pc;
         end

         OP_LOAD: begin
            ctrl.alu_op    = ALU_ADD;
            ctrl.alu_src   = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.mem_2_reg = 1'b1;
            ctrl.reg_write = 1'b1;
         end

         OP_STORE: begin
            // address is rs1 plus offset
            ctrl.alu_op    = ALU_ADD;
            ctrl.alu_src   = 1'b1;
            ctrl.mem_write = 1'b1;
         end

         default: begin
            // unsupported opcode, inert except for ALUOp
            ctrl.alu_op = ALU_R_TYPE;
         end
      endcase
   end

   assign dec.ctrl  = ctrl;
   assign dec.flush = flush;

endmodule

// File: hdl/decode_if.sv
// decode results between ID blocks

`timescale 1ns/1ps

`include "rv_cfg.svh"

interface decode_if
   import rv_ctrl_pkg::*;
();

   // from the control decoder
   ctrl_t                ctrl;
   logic                 flush;

   // from the immediate generator
   logic [`RV_XLEN-1:0]  imm;

   // register fields straight from the word
   logic [4:0]           rs1;
   logic [4:0]           rs2;
   logic [4:0]           rd;
   logic [2:0]           funct3;
   logic [6:0]           funct7;

   modport ctrl_src (
      output ctrl,
      output flush
   );

   modport imm_src (
      output imm
   );

   modport sink (
      input ctrl, flush, imm,
      input rs1, rs2, rd, funct3, funct7
   );

endinterface

// File: hdl/decode_stage.sv
// instruction decode stage top

`timescale 1ns/1ps

`include "rv_cfg.svh"

module decode_stage
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                id_valid,
   input  logic [`RV_ILEN-1:0] id_instr,
   input  logic [`RV_XLEN-1:0] predicted_pc,
   input  logic                branch_taken,
   output logic                ex_valid,
   output logic [1:0]          ex_alu_op,
   output logic                ex_alu_src,
   output logic                ex_mem_read,
   output logic                ex_mem_write,
   output logic                ex_mem_2_reg,
   output logic                ex_reg_write,
   output logic                ex_branch,
   output logic                ex_jump,
   output logic                ex_flush,
   output logic [`RV_XLEN-1:0] ex_imm,
   output logic [4:0]          ex_rs1,
   output logic [4:0]          ex_rs2,
   output logic [4:0]          ex_rd,
   output logic [2:0]          ex_funct3,
   output logic [6:0]          ex_funct7
);

   instr_u instr;
   ctrl_t  ex_ctrl;

   decode_if dec_if ();

   assign instr = id_instr;

   // register fields sit at fixed positions, R view covers them
   assign dec_if.rs1    = instr.r.rs1;
   assign dec_if.rs2    = instr.r.rs2;
   assign dec_if.rd     = instr.r.rd;
   assign dec_if.funct3 = instr.r.funct3;
   assign dec_if.funct7 = instr.r.funct7;

   control_unit control_unit_inst (
      .opcode       (instr.r.opcode),
      .predicted_pc (predicted_pc),
      .branch_taken (branch_taken),
      .dec          (dec_if.ctrl_src)
   );

   imm_gen imm_gen_inst (
      .instr (instr),
      .dec   (dec_if.imm_src)
   );

   id_ex_reg id_ex_reg_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (id_valid),
      .dec       (dec_if.sink),
      .ex_valid  (ex_valid),
      .ex_ctrl   (ex_ctrl),
      .ex_flush  (ex_flush),
      .ex_imm    (ex_imm),
      .ex_rs1    (ex_rs1),
      .ex_rs2    (ex_rs2),
      .ex_rd     (ex_rd),
      .ex_funct3 (ex_funct3),
      .ex_funct7 (ex_funct7)
   );

   // flatten the control bundle
   assign ex_alu_op    = ex_ctrl.alu_op;
   assign ex_alu_src   = ex_ctrl.alu_src;
   assign ex_mem_read  = ex_ctrl.mem_read;
   assign ex_mem_write = ex_ctrl.mem_write;
   assign ex_mem_2_reg = ex_ctrl.mem_2_reg;
   assign ex_reg_write = ex_ctrl.reg_write;
   assign ex_branch    = ex_ctrl.branch;
   assign ex_jump      = ex_ctrl.jump;

endmodule

// File: hdl/id_ex_reg.sv
// ID/EX pipeline register

`timescale 1ns/1ps

`include "rv_cfg.svh"

module id_ex_reg
   import rv_ctrl_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                valid,
   decode_if.sink              dec,
   output logic                ex_valid,
   output ctrl_t               ex_ctrl,
   output logic                ex_flush,
   output logic [`RV_XLEN-1:0] ex_imm,
   output logic [4:0]          ex_rs1,
   output logic [4:0]          ex_rs2,
   output logic [4:0]          ex_rd,
   output logic [2:0]          ex_funct3,
   output logic [6:0]          ex_funct7
);

   logic take;
   logic flush_q;

   // a latched flush request squashes whatever comes next,
   // so the request flop is the squash flag as well
   assign take = valid & ~flush_q;

   // control side
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
         ex_ctrl  <= CTRL_NOP;
         flush_q  <= 1'b0;
      end else begin
         ex_valid <= take;
         ex_ctrl  <= take ? dec.ctrl : CTRL_NOP;
         // bubbles never request a flush, which also clears the squash
         flush_q  <= take & dec.flush;
      end
   end

   assign ex_flush = flush_q;

   // payload side, qualified by ex_valid downstream
   always_ff @(posedge clk) begin
      ex_imm    <= dec.imm;
      ex_rs1    <= dec.rs1;
      ex_rs2    <= dec.rs2;
      ex_rd     <= dec.rd;
      ex_funct3 <= dec.funct3;
      ex_funct7 <= dec.funct7;
   end

endmodule

// File: hdl/imm_gen.sv
// immediate extraction and sign extension

`timescale 1ns/1ps

`include "rv_cfg.svh"

module imm_gen
   import rv_isa_pkg::*;
(
   input  instr_u     instr,
   decode_if.imm_src  dec
);

   logic                sign;
   logic [`RV_XLEN-1:0] imm;

   // every format keeps its sign in bit 31
   assign sign = instr.r.funct7[6];

   always_comb begin
      case (instr.r.opcode)
         OP_ALU_I, OP_LOAD: begin
            // I format, bits 31:20
            imm = {{(`RV_XLEN-12){sign}}, instr.r.funct7, instr.r.rs2};
         end

         OP_STORE: begin
            imm = {{(`RV_XLEN-12){sign}}, instr.s.imm_hi, instr.s.imm_lo};
         end

         OP_BRANCH_EQ: begin
            // B format, bit 7 moves up to imm[11]
            imm = {{(`RV_XLEN-13){sign}},
                   instr.s.imm_hi[6],
                   instr.s.imm_lo[0],
                   instr.s.imm_hi[5:0],
                   instr.s.imm_lo[4:1],
                   1'b0};
         end

         OP_JUMP: begin
            // J format: rs1 and funct3 hold imm[19:12], rs2[0] is imm[11]
            imm = {{(`RV_XLEN-21){sign}},
                   instr.r.funct7[6],
                   instr.r.rs1,
                   instr.r.funct3,
                   instr.r.rs2[0],
                   instr.r.funct7[5:0],
                   instr.r.rs2[4:1],
                   1'b0};
         end

         default: begin
            // R-type and unknown words carry no immediate
            imm = '0;
         end
      endcase
   end

   assign dec.imm = imm;

endmodule

// File: hdl/rv_cfg.svh
// datapath and instruction widths

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width of the pipeline
`define RV_XLEN 64

// instruction word width
`define RV_ILEN 32

`endif

// File: hdl/rv_ctrl_pkg.sv
// datapath control bundle

package rv_ctrl_pkg;

   import rv_isa_pkg::*;

   // control signals carried from ID into EX
   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src;
      logic    mem_read;
      logic    mem_write;
      logic    mem_2_reg;
      logic    reg_write;
      logic    branch;
      logic    jump;
   } ctrl_t;

   // bubble: nothing written, no memory access
   localparam ctrl_t CTRL_NOP = '{
      alu_op:    ALU_ADD,
      alu_src:   1'b0,
      mem_read:  1'b0,
      mem_write: 1'b0,
      mem_2_reg: 1'b0,
      reg_write: 1'b0,
      branch:    1'b0,
      jump:      1'b0
   };

endpackage

// File: hdl/rv_isa_pkg.sv
// RISC-V instruction set encodings

package rv_isa_pkg;

   // opcode[6:0] values, see the RISC-V greensheet
   typedef enum logic [6:0] {
      OP_ALU_R     = 7'b0110011,
      OP_ALU_I     = 7'b0010011,
      OP_BRANCH_EQ = 7'b1100011,
      OP_JUMP      = 7'b1101111,
      OP_LOAD      = 7'b0000011,
      OP_STORE     = 7'b0100011
   } opcode_e;

   // ALUOp handed to the ALU control in EX
   typedef enum logic [1:0] {
      ALU_ADD    = 2'b00,
      ALU_SUB    = 2'b01,
      ALU_R_TYPE = 2'b10
   } alu_op_e;

   // register-register layout
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } r_fmt_t;

   // store layout, immediate split around the register fields
   // the B format shares the same bit positions
   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
   } s_fmt_t;

   // one instruction word, two ways to slice it
   typedef union packed {
      r_fmt_t r;
      s_fmt_t s;
   } instr_u;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
   --top-module tb_decode_stage \
   -f vlog.f \
   --Mdir obj_dir \
   -o tb_decode_stage

./obj_dir/tb_decode_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
   exit 0
else
   exit 1
fi

// File: sim/tb_decode_stage.sv
// testbench for the decode stage

`timescale 1ns/1ps

`include "rv_cfg.svh"

module tb_decode_stage
   import rv_isa_pkg::*;
   import rv_ctrl_pkg::*;
();

   // reset, directed part, random stream and drain
   localparam int STIM_CYCLES = 10 + 40 + 400 + 4;
   localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 50;

   typedef struct packed {
      ctrl_t               ctrl;
      logic                flush;
      logic [`RV_XLEN-1:0] imm;
   } dec_exp_t;

   logic                clk;
   logic                rst_n;
   logic                id_valid;
   logic [`RV_ILEN-1:0] id_instr;
   logic [`RV_XLEN-1:0] predicted_pc;
   logic                branch_taken;
   logic                ex_valid;
   logic [1:0]          ex_alu_op;
   logic                ex_alu_src;
   logic                ex_mem_read;
   logic                ex_mem_write;
   logic                ex_mem_2_reg;
   logic                ex_reg_write;
   logic                ex_branch;
   logic                ex_jump;
   logic                ex_flush;
   logic [`RV_XLEN-1:0] ex_imm;
   logic [4:0]          ex_rs1;
   logic [4:0]          ex_rs2;
   logic [4:0]          ex_rd;
   logic [2:0]          ex_funct3;
   logic [6:0]          ex_funct7;
   ctrl_t               got_ctrl;

   // expectation for the next sample plus the squash flag of the model
   logic                exp_ready = 1'b0;
   logic                exp_valid;
   ctrl_t               exp_ctrl;
   logic                exp_flush;
   logic                exp_payload;
   logic [`RV_XLEN-1:0] exp_imm;
   logic [`RV_ILEN-1:0] exp_word;
   logic                squash = 1'b0;

   int                  seed = 30;
   int                  cycle = 0;
   int                  err_ctrl = 0;
   int                  err_imm = 0;
   int                  err_fields = 0;

   decode_stage decode_stage_inst (
      .clk (clk), .rst_n (rst_n), .id_valid (id_valid), .id_instr (id_instr),
      .predicted_pc (predicted_pc), .branch_taken (branch_taken),
      .ex_valid (ex_valid), .ex_alu_op (ex_alu_op), .ex_alu_src (ex_alu_src),
      .ex_mem_read (ex_mem_read), .ex_mem_write (ex_mem_write),
      .ex_mem_2_reg (ex_mem_2_reg), .ex_reg_write (ex_reg_write),
      .ex_branch (ex_branch), .ex_jump (ex_jump), .ex_flush (ex_flush),
      .ex_imm (ex_imm), .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2), .ex_rd (ex_rd),
      .ex_funct3 (ex_funct3), .ex_funct7 (ex_funct7)
   );

   assign got_ctrl = {ex_alu_op, ex_alu_src, ex_mem_read, ex_mem_write,
                      ex_mem_2_reg, ex_reg_write, ex_branch, ex_jump};

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // expected decode of one word from the ISA bit layout
   function automatic dec_exp_t ref_decode(input logic [`RV_ILEN-1:0] w,
                                           input logic [`RV_XLEN-1:0] ppc,
                                           input logic taken);
      dec_exp_t e;
      e       = '0;
      e.ctrl  = CTRL_NOP;
      case (w[6:0])
         OP_ALU_R: begin
            e.ctrl.alu_op    = ALU_R_TYPE;
            e.ctrl.reg_write = 1'b1;
         end
         OP_ALU_I: begin
            e.ctrl.alu_src   = 1'b1;
            e.ctrl.reg_write = 1'b1;
            e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
         end
         OP_LOAD: begin
            e.ctrl.alu_src   = 1'b1;
            e.ctrl.mem_read  = 1'b1;
            e.ctrl.mem_2_reg = 1'b1;
            e.ctrl.reg_write = 1'b1;
            e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
         end
         OP_STORE: begin
            e.ctrl.alu_src   = 1'b1;
            e.ctrl.mem_write = 1'b1;
            e.imm = {{(`RV_XLEN-12){w[31]}}, w[31:25], w[11:7]};
         end
         OP_BRANCH_EQ: begin
            e.ctrl.alu_op = ALU_SUB;
            e.ctrl.branch = 1'b1;
            e.flush       = taken;
            e.imm = {{(`RV_XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
         end
         OP_JUMP: begin
            e.ctrl.jump = 1'b1;
            e.flush     = (ppc == '0);
            e.imm = {{(`RV_XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
         end
         default: e.ctrl.alu_op = ALU_R_TYPE;
      endcase
      return e;
   endfunction

   task automatic check_ctrl(input ctrl_t got, input ctrl_t exp);
      if (got !== exp) begin
         $display("ERROR ex_ctrl got %h expected %h at %0t", got, exp, $time);
         err_ctrl++;
      end
   endtask

   task automatic check_imm(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
      if (got !== exp) begin
         $display("ERROR ex_imm got %h expected %h at %0t", got, exp, $time);
         err_imm++;
      end
   endtask

   task automatic check_fields(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
         err_fields++;
      end
   endtask

   // outputs are sampled on the falling edge once they have settled
   always @(negedge clk) begin
      dec_exp_t r;
      if (exp_ready) begin
         check_fields("ex_valid", 32'(ex_valid), 32'(exp_valid));
         check_fields("ex_flush", 32'(ex_flush), 32'(exp_flush));
         check_ctrl(got_ctrl, exp_ctrl);
         if (exp_payload) begin
            check_imm(ex_imm, exp_imm);
            check_fields("ex_rs1", 32'(ex_rs1), 32'(exp_word[19:15]));
            check_fields("ex_rs2", 32'(ex_rs2), 32'(exp_word[24:20]));
            check_fields("ex_rd", 32'(ex_rd), 32'(exp_word[11:7]));
            check_fields("ex_funct3", 32'(ex_funct3), 32'(exp_word[14:12]));
            check_fields("ex_funct7", 32'(ex_funct7), 32'(exp_word[31:25]));
         end
      end
      // inputs seen now are captured at the next rising edge
      r           = ref_decode(id_instr, predicted_pc, branch_taken);
      exp_valid   = rst_n && id_valid && !squash;
      exp_ctrl    = exp_valid ? r.ctrl : CTRL_NOP;
      exp_flush   = exp_valid && r.flush;
      exp_payload = rst_n && id_valid;
      exp_imm     = r.imm;
      exp_word    = id_instr;
      squash      = exp_flush;
      exp_ready   = 1'b1;
   end

   task automatic drive(input logic v, input logic [`RV_ILEN-1:0] w,
                        input logic [`RV_XLEN-1:0] ppc, input logic taken);
      @(posedge clk);
      id_valid     <= v;
      id_instr     <= w;
      predicted_pc <= ppc;
      branch_taken <= taken;
   endtask

   function automatic logic [`RV_ILEN-1:0] make_word(input logic [6:0] op, input logic sign);
      logic [`RV_ILEN-1:0] w;
      w        = $random(seed);
      w[6:0]   = op;
      w[31]    = sign;
      return w;
   endfunction

   function automatic logic [`RV_XLEN-1:0] rand_pc();
      return {$random(seed), $random(seed)} | 64'h1000;
   endfunction

   function automatic logic [6:0] pick_op(input int k);
      case (k)
         0: return OP_ALU_R;
         1: return OP_ALU_I;
         2: return OP_BRANCH_EQ;
         3: return OP_JUMP;
         4: return OP_LOAD;
         5: return OP_STORE;
         default: return 7'b1111111;
      endcase
   endfunction

   initial begin
      while (cycle < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle++;
      end
      $display("timeout: stimulus still running after %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int k;
      logic v;
      logic [`RV_XLEN-1:0] ppc;
      // a taken branch held during reset must not reach the outputs
      rst_n        <= 1'b0;
      id_valid     <= 1'b1;
      id_instr     <= make_word(OP_BRANCH_EQ, 1'b1);
      predicted_pc <= '0;
      branch_taken <= 1'b1;
      repeat (10) @(posedge clk);
      rst_n        <= 1'b1;
      id_valid     <= 1'b0;
      branch_taken <= 1'b0;
      // idle after reset keeps every output inactive
      repeat (3) drive(1'b0, '0, '0, 1'b0);
      // all opcodes and one unknown without flush
      for (k = 0; k < 7; k++) begin
         drive(1'b1, make_word(pick_op(k), $random(seed)), rand_pc(), 1'b0);
      end
      // both immediate signs per format
      for (k = 0; k < 6; k++) begin
         drive(1'b1, make_word(pick_op(k), 1'b0), rand_pc(), 1'b0);
         drive(1'b1, make_word(pick_op(k), 1'b1), rand_pc(), 1'b0);
      end
      // flush requests each followed by an idle slot
      drive(1'b1, make_word(OP_BRANCH_EQ, 1'b1), rand_pc(), 1'b1);
      drive(1'b0, '0, '0, 1'b0);
      drive(1'b1, make_word(OP_BRANCH_EQ, 1'b0), rand_pc(), 1'b0);
      drive(1'b1, make_word(OP_JUMP, 1'b0), '0, 1'b0);
      drive(1'b0, '0, '0, 1'b0);
      drive(1'b1, make_word(OP_JUMP, 1'b1), rand_pc(), 1'b0);
      // squash of the slot behind a flush and then recovery
      drive(1'b1, make_word(OP_BRANCH_EQ, 1'b0), rand_pc(), 1'b1);
      drive(1'b1, make_word(OP_ALU_R, 1'b0), rand_pc(), 1'b0);
      drive(1'b1, make_word(OP_ALU_I, 1'b1), rand_pc(), 1'b0);
      drive(1'b1, make_word(OP_JUMP, 1'b1), '0, 1'b0);
      drive(1'b0, '0, '0, 1'b0);
      drive(1'b1, make_word(OP_LOAD, 1'b1), rand_pc(), 1'b0);
      // mixed random stream
      for (k = 0; k < 400; k++) begin
         v   = (($random(seed) & 3) != 0);
         ppc = (($random(seed) & 3) == 0) ? '0 : rand_pc();
         drive(v, make_word(pick_op({$random(seed)} % 7), $random(seed)), ppc, $random(seed));
      end
      repeat (3) drive(1'b0, '0, '0, 1'b0);
      repeat (2) @(posedge clk);
      $display("error counts: ctrl %0d, imm %0d, fields %0d", err_ctrl, err_imm, err_fields);
      if (err_ctrl + err_imm + err_fields == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: vlog.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/decode_if.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/id_ex_reg.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv
